/* hdl/ftdi_bridge_consts.svh */
`ifndef FTDI_BRIDGE_CONSTS_SVH
`define FTDI_BRIDGE_CONSTS_SVH

////////////////////////////////////////
// Packet format
////////////////////////////////////////

`define FTDI_PKT_BITS   72 // One multiplexer packet
`define FTDI_PKT_BYTES  9  // Serial bytes per packet
`define FTDI_NUM_CHANS  8  // Multiplexer channels

////////////////////////////////////////
// Serial timing
////////////////////////////////////////

// Clocks per serial bit, short for simulation
// Board value is 37_500_000/115_200
`define FTDI_BAUD_PERIOD 8

// Receive buffer, one slot kept free
`define FTDI_RX_BUF_ADDR_BITS 4
`define FTDI_RX_HIGH_WATER    8 // CTS withdrawn at this occupancy

// LED timing
`define FTDI_ACT_TIMEOUT 64 // Activity stretch in clocks
`define FTDI_BLINK_BIT   3  // Error blink, 16-clock period

`endif

/* hdl/ftdi_bridge_pkg.sv */
`include "ftdi_bridge_consts.svh"

package ftdi_bridge_pkg;

	// One multiplexer packet, byte 0 in bits 7:0 goes first
	typedef logic [`FTDI_PKT_BITS-1:0] pkt_t;

	// One serial byte
	typedef logic [7:0] uart_byte_t;

	// Forward half of one channel
	typedef struct packed
	{
		logic vld;
		pkt_t data;
	} hss_pkt_t;

	// All channels side by side, channel 0 lowest
	typedef hss_pkt_t [`FTDI_NUM_CHANS-1:0] hss_bus_t;

	// One ready per channel
	typedef logic [`FTDI_NUM_CHANS-1:0] chan_mask_t;

	// Inputs of one status LED
	typedef struct packed
	{
		logic connected; // Steady level
		logic error;     // Pulse or level
		logic activity;  // Pulse per transfer
	} link_status_t;

endpackage

/* hdl/uart_byte_rx.sv */
`include "ftdi_bridge_consts.svh"

module uart_byte_rx
(
	input  logic                      clk_i,
	input  logic                      rst_i,
	input  logic                      rxd_i,      // Already synchronised
	output ftdi_bridge_pkg::uart_byte_t byte_o,
	output logic                      byte_vld_o, // One clock per good byte
	output logic                      frame_err_o // One clock per bad stop bit
);

	localparam int BAUD_BITS = $clog2(`FTDI_BAUD_PERIOD);
	localparam logic [BAUD_BITS-1:0] BAUD_LAST = BAUD_BITS'(`FTDI_BAUD_PERIOD - 1);
	localparam logic [BAUD_BITS-1:0] HALF_LAST = BAUD_BITS'(`FTDI_BAUD_PERIOD / 2 - 1);

	typedef enum logic [1:0] {S_IDLE, S_START, S_DATA, S_STOP} state_t;

	state_t                      state_q;
	logic [BAUD_BITS-1:0]        baud_q;  // Clocks into current bit
	logic [2:0]                  bit_q;   // Data bit index
	ftdi_bridge_pkg::uart_byte_t shift_q; // LSB arrives first

	assign byte_o = shift_q;

	////////////////////////////////////////
	// Bit timing FSM
	////////////////////////////////////////

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			state_q     <= S_IDLE;
			baud_q      <= '0;
			bit_q       <= '0;
			byte_vld_o  <= 1'b0;
			frame_err_o <= 1'b0;
		end
		else
		begin
			byte_vld_o  <= 1'b0; // Strobes by default
			frame_err_o <= 1'b0;
			case (state_q)
				S_IDLE:
					if (!rxd_i)
					begin
						state_q <= S_START; // Falling edge seen
						baud_q  <= '0;
					end
				S_START:
					if (baud_q == HALF_LAST)
					begin
						baud_q  <= '0;
						bit_q   <= '0;
						state_q <= rxd_i ? S_IDLE : S_DATA; // Glitch rejected
					end
					else
						baud_q <= baud_q + 1'b1;
				S_DATA:
					if (baud_q == BAUD_LAST)
					begin
						baud_q <= '0;
						bit_q  <= bit_q + 1'b1;
						if (bit_q == 3'd7)
							state_q <= S_STOP;
					end
					else
						baud_q <= baud_q + 1'b1;
				default: // S_STOP
					if (baud_q == BAUD_LAST)
					begin
						byte_vld_o  <= rxd_i;  // Stop bit high
						frame_err_o <= !rxd_i; // Stop bit low
						state_q     <= S_IDLE;
					end
					else
						baud_q <= baud_q + 1'b1;
			endcase
		end
	end

	// Mid-bit sampling of the data bits
	always_ff @(posedge clk_i)
	begin
		if (state_q == S_DATA && baud_q == BAUD_LAST)
			shift_q <= {rxd_i, shift_q[7:1]};
	end

endmodule

/* hdl/uart_byte_tx.sv */
`include "ftdi_bridge_consts.svh"

module uart_byte_tx
(
	input  logic                        clk_i,
	input  logic                        rst_i,
	input  ftdi_bridge_pkg::uart_byte_t byte_i,
	input  logic                        start_i, // Ignored while busy
	output logic                        txd_o,
	output logic                        busy_o
);

	localparam int BAUD_BITS = $clog2(`FTDI_BAUD_PERIOD);
	localparam logic [BAUD_BITS-1:0] BAUD_LAST = BAUD_BITS'(`FTDI_BAUD_PERIOD - 1);

	logic [9:0]           frame_q; // Stop, data, start; bit 0 on the line
	logic [BAUD_BITS-1:0] baud_q;
	logic [3:0]           bit_q;   // Frame bit on the line
	logic                 busy_q;

	assign busy_o = busy_q;
	assign txd_o  = busy_q ? frame_q[0] : 1'b1; // Idle high

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			busy_q <= 1'b0;
			baud_q <= '0;
			bit_q  <= '0;
		end
		else if (start_i && !busy_q)
		begin
			busy_q <= 1'b1;
			baud_q <= '0;
			bit_q  <= '0;
		end
		else if (busy_q && baud_q == BAUD_LAST)
		begin
			baud_q <= '0;
			bit_q  <= bit_q + 1'b1;
			if (bit_q == 4'd9)
				busy_q <= 1'b0; // Stop bit done
		end
		else if (busy_q)
			baud_q <= baud_q + 1'b1;
	end

	// Frame shifter
	always_ff @(posedge clk_i)
	begin
		if (start_i && !busy_q)
			frame_q <= {1'b1, byte_i, 1'b0};
		else if (busy_q && baud_q == BAUD_LAST)
			frame_q <= {1'b1, frame_q[9:1]};
	end

endmodule

/* hdl/uart_pkt_rx.sv */
`include "ftdi_bridge_consts.svh"

module uart_pkt_rx
(
	input  logic                        clk_i,
	input  logic                        rst_i,
	input  ftdi_bridge_pkg::uart_byte_t byte_i,
	input  logic                        byte_vld_i,
	input  logic                        frame_err_i,
	output ftdi_bridge_pkg::hss_pkt_t   pkt_o,     // Oldest buffered packet
	input  logic                        pkt_rdy_i,
	output logic                        cts_n_o,   // Registered, low means send
	output logic                        drop_o     // Packet lost to a full buffer
);

	localparam int AW    = `FTDI_RX_BUF_ADDR_BITS;
	localparam int DEPTH = 1 << AW;
	localparam logic [AW-1:0] FULL = {AW{1'b1}}; // One slot unused
	localparam logic [AW-1:0] HIGH_WATER = AW'(`FTDI_RX_HIGH_WATER);
	localparam logic [3:0] LAST_BYTE = 4'(`FTDI_PKT_BYTES - 1);

	logic [3:0]            cnt_q;   // Bytes of the current packet
	ftdi_bridge_pkg::pkt_t asm_q;   // Assembly shift register
	logic                  wr_q;    // Packet complete, write next clock
	ftdi_bridge_pkg::pkt_t pkt_mem [DEPTH];
	logic [AW-1:0]         wr_ptr_q;
	logic [AW-1:0]         rd_ptr_q;
	logic [AW-1:0]         occ_q;   // Packets held
	logic                  do_wr;
	logic                  do_rd;

	assign do_wr = wr_q && occ_q != FULL;
	assign do_rd = pkt_o.vld && pkt_rdy_i;

	assign pkt_o.vld  = occ_q != '0;
	assign pkt_o.data = pkt_mem[rd_ptr_q];

	////////////////////////////////////////
	// Byte assembly
	////////////////////////////////////////

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			cnt_q <= '0;
			wr_q  <= 1'b0;
		end
		else
		begin
			wr_q <= 1'b0;
			if (frame_err_i)
				cnt_q <= '0; // Partial packet abandoned
			else if (byte_vld_i)
			begin
				if (cnt_q == LAST_BYTE)
				begin
					cnt_q <= '0;
					wr_q  <= 1'b1;
				end
				else
					cnt_q <= cnt_q + 1'b1;
			end
		end
	end

	// New byte enters at the top, so byte 0 ends up in bits 7:0
	always_ff @(posedge clk_i)
	begin
		if (byte_vld_i)
			asm_q <= {byte_i, asm_q[`FTDI_PKT_BITS-1:8]};
	end

	////////////////////////////////////////
	// Packet buffer
	////////////////////////////////////////

	always_ff @(posedge clk_i)
	begin
		if (do_wr)
			pkt_mem[wr_ptr_q] <= asm_q;
	end

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			occ_q    <= '0;
			cts_n_o  <= 1'b0; // Clear to send
			drop_o   <= 1'b0;
		end
		else
		begin
			if (do_wr)
				wr_ptr_q <= wr_ptr_q + 1'b1;
			if (do_rd)
				rd_ptr_q <= rd_ptr_q + 1'b1;
			if (do_wr && !do_rd)
				occ_q <= occ_q + 1'b1;
			else if (do_rd && !do_wr)
				occ_q <= occ_q - 1'b1;
			drop_o  <= wr_q && occ_q == FULL;
			cts_n_o <= occ_q >= HIGH_WATER; // Host back-pressure
		end
	end

endmodule

/* hdl/uart_pkt_tx.sv */
`include "ftdi_bridge_consts.svh"

module uart_pkt_tx
(
	input  logic                      clk_i,
	input  logic                      rst_i,
	input  ftdi_bridge_pkg::hss_pkt_t pkt_i,
	output logic                      pkt_rdy_o, // High only while empty
	output logic                      txd_o
);

	localparam logic [3:0] NUM_BYTES = 4'(`FTDI_PKT_BYTES);

	logic                        rdy_q;
	logic [3:0]                  cnt_q;   // Bytes handed to the transmitter
	ftdi_bridge_pkg::pkt_t       shift_q; // Next byte in bits 7:0
	ftdi_bridge_pkg::uart_byte_t byte_q;
	logic                        start_q;
	logic                        busy;
	logic                        take;
	logic                        idle;    // Transmitter free, no start in flight

	assign pkt_rdy_o = rdy_q;
	assign take      = rdy_q && pkt_i.vld;
	assign idle      = !rdy_q && !busy && !start_q;

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
		begin
			rdy_q   <= 1'b1;
			cnt_q   <= '0;
			start_q <= 1'b0;
		end
		else
		begin
			start_q <= 1'b0;
			if (take)
			begin
				rdy_q <= 1'b0;
				cnt_q <= '0;
			end
			else if (idle && cnt_q == NUM_BYTES)
				rdy_q <= 1'b1; // Last stop bit finished
			else if (idle)
			begin
				start_q <= 1'b1;
				cnt_q   <= cnt_q + 1'b1;
			end
		end
	end

	// Packet holder, low byte leaves first
	always_ff @(posedge clk_i)
	begin
		if (take)
			shift_q <= pkt_i.data;
		else if (idle && cnt_q != NUM_BYTES)
		begin
			byte_q  <= shift_q[7:0];
			shift_q <= shift_q >> 8;
		end
	end

	uart_byte_tx i_uart_byte_tx
	(
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.byte_i  (byte_q),
		.start_i (start_q),
		.txd_o   (txd_o),
		.busy_o  (busy)
	);

endmodule

/* hdl/status_led_gen.sv */
`include "ftdi_bridge_consts.svh"

module status_led_gen
(
	input  logic                                clk_i,
	input  logic                                rst_i,
	input  ftdi_bridge_pkg::link_status_t [1:0] status_i,
	output logic [1:0]                          led_o
);

	localparam int STRETCH_BITS = $clog2(`FTDI_ACT_TIMEOUT + 1);
	localparam logic [STRETCH_BITS-1:0] RELOAD = STRETCH_BITS'(`FTDI_ACT_TIMEOUT);

	logic [`FTDI_BLINK_BIT:0] blink_q; // Shared by both LEDs

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			blink_q <= '0;
		else
			blink_q <= blink_q + 1'b1;
	end

	////////////////////////////////////////
	// Per-link stretchers
	////////////////////////////////////////

	for (genvar i = 0; i < 2; i++)
	begin : g_link
		logic [STRETCH_BITS-1:0] act_q;
		logic [STRETCH_BITS-1:0] err_q;

		always_ff @(posedge clk_i)
		begin
			if (rst_i)
			begin
				act_q <= '0;
				err_q <= '0;
			end
			else
			begin
				if (status_i[i].activity)
					act_q <= RELOAD;
				else if (act_q != '0)
					act_q <= act_q - 1'b1;
				if (status_i[i].error)
					err_q <= RELOAD; // Held while level stays high
				else if (err_q != '0)
					err_q <= err_q - 1'b1;
			end
		end

		// Error beats activity beats plain connected
		always_comb
		begin
			if (err_q != '0)
				led_o[i] = blink_q[`FTDI_BLINK_BIT];
			else if (act_q != '0)
				led_o[i] = !status_i[i].connected; // Flicker on traffic
			else
				led_o[i] = status_i[i].connected;
		end
	end

endmodule

/* hdl/ftdi_bridge_top.sv */
`include "ftdi_bridge_consts.svh"

module ftdi_bridge_top
(
	input  logic                        clk_i,
	input  logic                        rst_i,
	input  logic                        ftdi_txd_i,   // Host to FPGA
	output logic                        ftdi_rxd_o,   // FPGA to host
	output logic                        ftdi_cts_n_o,
	output ftdi_bridge_pkg::hss_bus_t   hss_tx_o,     // Toward SpiNNaker
	input  ftdi_bridge_pkg::chan_mask_t hss_tx_rdy_i,
	input  ftdi_bridge_pkg::hss_bus_t   hss_rx_i,     // From SpiNNaker
	output ftdi_bridge_pkg::chan_mask_t hss_rx_rdy_o,
	input  logic                        hss_handshake_complete_i,
	input  logic                        hss_version_mismatch_i,
	output logic [1:0]                  leds_o        // 0 HSS, 1 UART
);

	logic [1:0]                  sync_q;    // Line synchroniser
	ftdi_bridge_pkg::uart_byte_t rx_byte;
	logic                        rx_byte_vld;
	logic                        rx_frame_err;
	ftdi_bridge_pkg::hss_pkt_t   uart_rx_pkt; // Host packets out
	logic                        uart_drop;
	logic                        uart_tx_rdy;
	logic                        hss_activity;
	logic                        uart_activity;
	ftdi_bridge_pkg::link_status_t [1:0] status;

	////////////////////////////////////////
	// Serial input
	////////////////////////////////////////

	always_ff @(posedge clk_i)
	begin
		if (rst_i)
			sync_q <= 2'b11; // Line idles high
		else
			sync_q <= {sync_q[0], ftdi_txd_i};
	end

	uart_byte_rx i_uart_byte_rx
	(
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.rxd_i       (sync_q[1]),
		.byte_o      (rx_byte),
		.byte_vld_o  (rx_byte_vld),
		.frame_err_o (rx_frame_err)
	);

	uart_pkt_rx i_uart_pkt_rx
	(
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.byte_i      (rx_byte),
		.byte_vld_i  (rx_byte_vld),
		.frame_err_i (rx_frame_err),
		.pkt_o       (uart_rx_pkt),
		.pkt_rdy_i   (hss_tx_rdy_i[0]),
		.cts_n_o     (ftdi_cts_n_o),
		.drop_o      (uart_drop)
	);

	uart_pkt_tx i_uart_pkt_tx
	(
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.pkt_i     (hss_rx_i[0]),
		.pkt_rdy_o (uart_tx_rdy),
		.txd_o     (ftdi_rxd_o)
	);

	////////////////////////////////////////
	// Channel routing and activity
	////////////////////////////////////////

	always_comb
	begin
		hss_tx_o        = '0;          // Idle channels never send
		hss_tx_o[0]     = uart_rx_pkt;
		hss_rx_rdy_o    = '1;          // Idle channels sink everything
		hss_rx_rdy_o[0] = uart_tx_rdy;
		hss_activity    = 1'b0;
		for (int c = 0; c < `FTDI_NUM_CHANS; c++)
			hss_activity |= (hss_tx_o[c].vld & hss_tx_rdy_i[c])
			              | (hss_rx_i[c].vld & hss_rx_rdy_o[c]);
	end

	assign uart_activity = (uart_rx_pkt.vld & hss_tx_rdy_i[0])
	                     | (hss_rx_i[0].vld & uart_tx_rdy);

	////////////////////////////////////////
	// Status LEDs
	////////////////////////////////////////

	assign status[0] = '{connected: hss_handshake_complete_i,
	                     error:     hss_version_mismatch_i,
	                     activity:  hss_activity};
	assign status[1] = '{connected: !ftdi_cts_n_o,
	                     error:     uart_drop | rx_frame_err,
	                     activity:  uart_activity};

	status_led_gen i_status_led_gen
	(
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.status_i (status),
		.led_o    (leds_o)
	);

endmodule

/* verification/ftdi_bridge_checker.sv */
`include "ftdi_bridge_consts.svh"

module ftdi_bridge_checker
(
	input logic                        clk_i,
	input logic                        rst_i,
	input ftdi_bridge_pkg::hss_bus_t   tx_bus_i,
	input ftdi_bridge_pkg::chan_mask_t tx_rdy_i,
	input ftdi_bridge_pkg::chan_mask_t rx_rdy_i,
	input logic                        rxd_i
);

	int   fail_cnt = 0; // Read by the testbench
	logic idle_vld;     // Any vld on channels 1 up

	always_comb
	begin
		idle_vld = 1'b0;
		for (int c = 1; c < `FTDI_NUM_CHANS; c++)
			idle_vld |= tx_bus_i[c].vld;
	end

	////////////////////////////////////////
	// Channel tie-offs
	////////////////////////////////////////

	idle_tx_quiet: assert property (@(posedge clk_i) disable iff (rst_i) !idle_vld)
	else
	begin
		$error("vld high on an unused transmit channel");
		fail_cnt++;
	end

	idle_rx_ready: assert property (@(posedge clk_i) disable iff (rst_i)
		&rx_rdy_i[`FTDI_NUM_CHANS-1:1])
	else
	begin
		$error("rdy low on an unused receive channel");
		fail_cnt++;
	end

	// Packet held until taken
	tx_hold: assert property (@(posedge clk_i) disable iff (rst_i)
		(tx_bus_i[0].vld && !tx_rdy_i[0]) |=> (tx_bus_i[0].vld && $stable(tx_bus_i[0].data)))
	else
	begin
		$error("channel 0 packet changed before transfer");
		fail_cnt++;
	end

	line_idle: assert property (@(posedge clk_i) $fell(rst_i) |-> rxd_i)
	else
	begin
		$error("serial line not idle after reset");
		fail_cnt++;
	end

endmodule

bind ftdi_bridge_top ftdi_bridge_checker i_ftdi_bridge_checker
(
	.clk_i    (clk_i),
	.rst_i    (rst_i),
	.tx_bus_i (hss_tx_o),
	.tx_rdy_i (hss_tx_rdy_i),
	.rx_rdy_i (hss_rx_rdy_o),
	.rxd_i    (ftdi_rxd_o)
);

/* verification/ftdi_bridge_tb.sv */
`include "ftdi_bridge_consts.svh"

module ftdi_bridge_tb;

	localparam int BAUD      = `FTDI_BAUD_PERIOD;
	localparam int NBYTES    = `FTDI_PKT_BYTES;
	localparam int BUF_SLOTS = (1 << `FTDI_RX_BUF_ADDR_BITS) - 1; // One slot kept free
	localparam int IDLE_WAIT = `FTDI_ACT_TIMEOUT + 8;
	localparam int PKT_CLKS  = 90 * BAUD; // Nine serial frames
	localparam int LINE_CLKS = 64;
	localparam string VEC_FILE = "verification/ftdi_bridge_vectors.txt";

	logic                        clk;
	logic                        rst;
	logic                        ftdi_txd;
	logic                        ftdi_rxd;
	logic                        ftdi_cts_n;
	ftdi_bridge_pkg::hss_bus_t   hss_tx;
	ftdi_bridge_pkg::chan_mask_t hss_tx_rdy;
	ftdi_bridge_pkg::hss_bus_t   hss_rx;
	ftdi_bridge_pkg::chan_mask_t hss_rx_rdy;
	logic                        hs_complete;
	logic                        version_mismatch;
	logic [1:0]                  leds;

	ftdi_bridge_pkg::pkt_t host_exp_q[$]; // Due on channel 0 out
	ftdi_bridge_pkg::pkt_t line_exp_q[$]; // Due on the serial line
	logic rdy_hold;   // Channel 0 ready forced low
	int   held = 0;   // Buffer occupancy model while held
	int   budget = 0;
	int   limit = 0;  // Zero until the vectors are counted
	int   cycles = 0;

	ftdi_bridge_top i_ftdi_bridge_top
	(
		.clk_i                    (clk),
		.rst_i                    (rst),
		.ftdi_txd_i               (ftdi_txd),
		.ftdi_rxd_o               (ftdi_rxd),
		.ftdi_cts_n_o             (ftdi_cts_n),
		.hss_tx_o                 (hss_tx),
		.hss_tx_rdy_i             (hss_tx_rdy),
		.hss_rx_i                 (hss_rx),
		.hss_rx_rdy_o             (hss_rx_rdy),
		.hss_handshake_complete_i (hs_complete),
		.hss_version_mismatch_i   (version_mismatch),
		.leds_o                   (leds)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////
	// Failure reporting
	////////////////////////////////////////

	task automatic abort_run(input string why);
		$display("ERRORS FOUND");
		$fatal(1, "%s", why);
	endtask

	task automatic compare(input string name, input logic [71:0] expected,
		input logic [71:0] actual);
		if (expected !== actual)
		begin
			$display("Fail %s: expected %0h, actual %0h", name, expected, actual);
			abort_run({"Value mismatch in ", name});
		end
	endtask

	// Run limit and bound assertion watch
	always @(posedge clk)
	begin
		cycles++;
		if (limit > 0 && cycles >= limit)
			abort_run($sformatf("Timeout, run went past %0d cycles", limit));
		else if (i_ftdi_bridge_top.i_ftdi_bridge_checker.fail_cnt != 0)
			abort_run("An assertion in the bound checker failed");
	end

	// Random ready gaps on channel 0
	initial
	begin
		void'($urandom(32'hce811f0d));
		forever
		begin
			@(posedge clk);
			#1;
			hss_tx_rdy[0] = !rdy_hold && ($urandom % 4 != 0); // About one gap in four
		end
	end

	////////////////////////////////////////
	// Host side serial driver
	////////////////////////////////////////

	task automatic send_byte(input logic [7:0] value, input logic stop);
		logic [9:0] frame;
		frame = {stop, value, 1'b0}; // Start bit first
		for (int i = 0; i < 10; i++)
		begin
			@(posedge clk);
			#1;
			ftdi_txd = frame[i];
			repeat (BAUD - 1) @(posedge clk);
		end
	endtask

	task automatic send_packet(input ftdi_bridge_pkg::pkt_t pkt);
		for (int j = 0; j < NBYTES; j++)
			send_byte(pkt[8 * j +: 8], 1'b1); // Low byte first
	endtask

	task automatic host_packets(input int count, input ftdi_bridge_pkg::pkt_t first);
		ftdi_bridge_pkg::pkt_t pkt;
		for (int k = 0; k < count; k++)
		begin
			pkt = first + ftdi_bridge_pkg::pkt_t'(k);
			send_packet(pkt);
			if (!rdy_hold)
				host_exp_q.push_back(pkt);
			else if (held < BUF_SLOTS)
			begin
				host_exp_q.push_back(pkt);
				held++;
			end // else dropped on a full buffer
		end
	endtask

	task automatic bad_byte(input int good, input logic [7:0] value);
		for (int j = 0; j < good; j++)
			send_byte(value, 1'b1); // Start of a partial packet
		send_byte(value, 1'b0);
		@(posedge clk);
		#1;
		ftdi_txd = 1'b1;
		repeat (2 * BAUD) @(posedge clk); // Idle before the next frame
	endtask

	////////////////////////////////////////
	// Channel side and monitors
	////////////////////////////////////////

	task automatic chan_packet(input int chan, input ftdi_bridge_pkg::pkt_t data);
		@(posedge clk);
		#1;
		hss_rx[chan].vld  = 1'b1;
		hss_rx[chan].data = data;
		@(negedge clk);
		while (!hss_rx_rdy[chan])
			@(negedge clk);
		if (chan == 0)
			line_exp_q.push_back(data); // Only channel 0 reaches the host
		@(posedge clk);
		#1;
		hss_rx[chan].vld = 1'b0;
	endtask

	// Transfer decided at the next rising edge
	always @(negedge clk)
	begin
		if (!rst && hss_tx[0].vld && hss_tx_rdy[0])
		begin
			if (host_exp_q.size() == 0)
				abort_run("Packet on channel 0 with no host packet pending");
			else
				compare("host packet on channel 0", host_exp_q.pop_front(), hss_tx[0].data);
		end
	end

	initial
	begin : serial_decoder
		ftdi_bridge_pkg::pkt_t got;
		logic [7:0]            rx_byte;
		int                    nb;
		nb  = 0;
		got = '0;
		forever
		begin
			@(negedge clk);
			if (!rst && ftdi_rxd === 1'b0)
			begin
				if (nb == 0 && line_exp_q.size() == 0)
					abort_run("Serial output with no channel 0 packet sent");
				else
				begin
					repeat (BAUD / 2) @(negedge clk); // Middle of start bit
					compare("serial start bit", 1'b0, ftdi_rxd);
					for (int i = 0; i < 8; i++)
					begin
						repeat (BAUD) @(negedge clk);
						rx_byte[i] = ftdi_rxd; // LSB first
					end
					repeat (BAUD) @(negedge clk);
					compare("serial stop bit", 1'b1, ftdi_rxd);
					got[8 * nb +: 8] = rx_byte;
					nb++;
					if (nb == NBYTES)
					begin
						compare("channel 0 packet on serial line",
							line_exp_q.pop_front(), got);
						nb = 0;
					end
				end
			end
		end
	end

	task automatic wait_drain();
		while (host_exp_q.size() != 0 || line_exp_q.size() != 0)
			@(posedge clk);
	endtask

	task automatic check_cts(input int expected);
		repeat (4) @(posedge clk);
		@(negedge clk);
		compare("clear to send", expected, ftdi_cts_n);
	endtask

	// exp_hss of 2 means blinking
	task automatic check_leds(input int hsc, input int mism, input int exp_hss, input int exp_uart);
		logic saw0;
		logic saw1;
		@(posedge clk);
		#1;
		hs_complete      = hsc[0];
		version_mismatch = mism[0];
		wait_drain();
		repeat (IDLE_WAIT) @(posedge clk);
		@(negedge clk);
		saw0 = 1'b0;
		saw1 = 1'b0;
		if (exp_hss == 2)
		begin
			repeat (16)
			begin
				@(negedge clk);
				saw0 |= !leds[0];
				saw1 |= leds[0];
			end
			compare("hss led blink", 2'b11, {saw1, saw0});
		end
		else
			compare("hss led", exp_hss, leds[0]);
		compare("uart led", exp_uart, leds[1]);
	endtask

	////////////////////////////////////////
	// Vector file
	////////////////////////////////////////

	// Only the run budget is summed when exec is low
	task automatic run_file(input bit exec);
		int    fd;
		int    a;
		int    b;
		int    c;
		int    d;
		int    cost;
		bit    ok;
		string op;
		string rest;
		ftdi_bridge_pkg::pkt_t data;
		fd = $fopen(VEC_FILE, "r");
		if (fd == 0)
			abort_run({"Could not open ", VEC_FILE});
		else
		begin
			while ($fscanf(fd, "%s", op) == 1)
			begin
				if (op.substr(0, 0) == "#")
					void'($fgets(rest, fd)); // Column notes
				else
				begin
					cost = LINE_CLKS;
					case (op)
						"hpkt":
						begin
							ok = $fscanf(fd, "%d %h", a, data) == 2;
							cost += a * PKT_CLKS;
							if (exec && ok)
								host_packets(a, data);
						end
						"hbad":
						begin
							ok = $fscanf(fd, "%d %h", a, b) == 2;
							cost += PKT_CLKS;
							if (exec && ok)
								bad_byte(a, b[7:0]);
						end
						"chan":
						begin
							ok = $fscanf(fd, "%d %h", a, data) == 2;
							cost += PKT_CLKS;
							if (exec && ok)
								chan_packet(a, data);
						end
						"hold":
						begin
							ok = $fscanf(fd, "%d", a) == 1;
							if (exec && ok)
							begin
								repeat (BAUD) @(posedge clk); // Last host packet lands
								rdy_hold = 1'b0;
								wait_drain(); // Buffer empty before the mode changes
								rdy_hold = a[0];
								held     = 0;
							end
						end
						"leds":
						begin
							ok = $fscanf(fd, "%d %d %d %d", a, b, c, d) == 4;
							if (exec && ok)
								check_leds(a, b, c, d);
						end
						"cts":
						begin
							ok = $fscanf(fd, "%d", a) == 1;
							if (exec && ok)
								check_cts(a);
						end
						default:
							ok = 1'b0;
					endcase
					if (!ok)
						abort_run({"Malformed vector line starting with ", op});
					else if (!exec)
						budget += cost;
				end
			end
			$fclose(fd);
		end
	endtask

	initial
	begin
		rst              = 1'b1;
		ftdi_txd         = 1'b1; // Line idle
		hss_tx_rdy       = '1;
		hss_rx           = '0;
		hs_complete      = 1'b0;
		version_mismatch = 1'b0;
		rdy_hold         = 1'b0;
		run_file(1'b0);
		limit = budget * 3 / 2;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		run_file(1'b1);
		wait_drain();
		repeat (IDLE_WAIT) @(posedge clk); // Late packets would show here
		if (i_ftdi_bridge_top.i_ftdi_bridge_checker.fail_cnt == 0)
		begin
			$display("NO ERRORS");
			$finish;
		end
		else
			abort_run("An assertion in the bound checker failed");
	end

endmodule

/* verification/ftdi_bridge_vectors.txt */
# op fields: hpkt count first_hex (later packets count up) | hbad good_bytes byte_hex
# chan channel data_hex | hold 1_or_0 | leds handshake mismatch hss_led(2 blink) uart_led | cts cts_n
cts 0
hpkt 1 0123456789abcdef5a
hpkt 2 f0e1d2c3b4a5968778
chan 0 1122334455667788ff
chan 3 deadbeefcafef00d42
chan 0 a5a5a5a5a5a5a5a501
chan 7 000000000000000001
leds 1 0 1 1
hold 1
hpkt 8 100000000000000000
cts 1
hpkt 8 100000000000000008
hold 0
cts 0
hbad 4 3c
hpkt 1 55aa55aa55aa55aa55
hbad 0 81
hpkt 1 7e7e7e7e7e7e7e7e7e
leds 1 1 2 1
leds 0 0 0 1
leds 1 0 1 1

/* list.f */
+incdir+hdl
hdl/ftdi_bridge_pkg.sv
hdl/uart_byte_rx.sv
hdl/uart_byte_tx.sv
hdl/uart_pkt_rx.sv
hdl/uart_pkt_tx.sv
hdl/status_led_gen.sv
hdl/ftdi_bridge_top.sv
verification/ftdi_bridge_checker.sv
verification/ftdi_bridge_tb.sv
